/* src/glb_pkg.sv */
/*
 * Global buffer package: bank count, word and address widths,
 * bank mask and index types, and the write, read and lane command structs
 */
package glb_pkg;

    // Bank count sets the mask width
    localparam int NUM_BANK   = 4;
    localparam int DATA_W     = 32;
    localparam int ADDR_W     = 8;
    localparam int LEN_W      = 8;
    localparam int BANK_IDX_W = $clog2(NUM_BANK);

    // Basic words
    typedef logic [DATA_W-1:0]     word_t;
    typedef logic [ADDR_W-1:0]     addr_t;
    typedef logic [LEN_W-1:0]      len_t;

    // One bit per bank owned by a port
    typedef logic [NUM_BANK-1:0]   bank_mask_t;
    typedef logic [BANK_IDX_W-1:0] bank_idx_t;

    // Loader to buffer write port
    typedef struct packed {
        addr_t addr;
        word_t data;
    } wr_req_t;

    // Fetcher to buffer read address
    typedef struct packed {
        addr_t addr;
    } rd_req_t;

    // Start command of one lane
    typedef struct packed {
        len_t len;
    } lane_cmd_t;

endpackage

/* src/glb_bank.sv */
/*
 * Single SRAM bank, write channel plus read channel
 * with a one-entry output register held under back-pressure
 */
`timescale 1ns/100ps

module glb_bank #(
    parameter int BANK_WORDS = 16
) (
    input  logic                          clk,
    input  logic                          arst_n_i,
    input  logic                          wr_vld_i,
    input  logic [$clog2(BANK_WORDS)-1:0] wr_addr_i,
    input  glb_pkg::word_t                wr_data_i,
    input  logic                          ar_vld_i,
    input  logic [$clog2(BANK_WORDS)-1:0] ar_addr_i,
    output logic                          ar_rdy_o,
    output logic                          rd_vld_o,
    input  logic                          rd_rdy_i,
    output glb_pkg::word_t                rd_data_o
);
    import glb_pkg::*;

    // Storage and read register
    word_t mem [BANK_WORDS];
    word_t rd_data_q;
    logic  rd_vld_q;
    logic  ar_hs;

    // Accept an address when the register is empty or drains now
    assign ar_rdy_o = !rd_vld_q || rd_rdy_i;
    assign ar_hs    = ar_vld_i && ar_rdy_o;

    // Array write, always accepted
    always_ff @(posedge clk) begin
        if (wr_vld_i) begin
            mem[wr_addr_i] <= wr_data_i;
        end
    end

    // Output register loads only on an address handshake
    always_ff @(posedge clk) begin
        if (ar_hs) begin
            rd_data_q <= mem[ar_addr_i];
        end
    end

    // Valid flag
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            rd_vld_q <= 1'b0;
        end else if (ar_hs) begin
            rd_vld_q <= 1'b1;
        end else if (rd_rdy_i) begin
            rd_vld_q <= 1'b0;
        end
    end

    assign rd_vld_o  = rd_vld_q;
    assign rd_data_o = rd_data_q;

endmodule

/* src/glb_port_map.sv */
/*
 * Port address to bank and in-bank word mapping from a bank mask
 */
`timescale 1ns/100ps

module glb_port_map #(
    parameter int BANK_WORDS = 16
) (
    input  glb_pkg::bank_mask_t           mask_i,
    input  glb_pkg::addr_t                addr_i,
    output glb_pkg::bank_idx_t            bank_o,
    output logic [$clog2(BANK_WORDS)-1:0] word_o,
    output logic                          owned_o
);
    import glb_pkg::*;

    localparam int WORD_W = $clog2(BANK_WORDS);
    localparam int SPAN_W = $clog2(NUM_BANK * BANK_WORDS + 1);
    localparam int CNT_W  = $clog2(NUM_BANK + 1);

    bank_idx_t         first_bank;
    logic [CNT_W-1:0]  bank_cnt;
    logic [SPAN_W-1:0] span;
    logic [SPAN_W-1:0] offset;

    // Lowest flagged bank and number of flagged banks
    always_comb begin
        first_bank = '0;
        bank_cnt   = '0;
        for (int b = NUM_BANK - 1; b >= 0; b--) begin
            if (mask_i[b]) begin
                first_bank = BANK_IDX_W'(b);
                bank_cnt   = bank_cnt + CNT_W'(1);
            end
        end
    end

    assign owned_o = |mask_i;

    // Span of the port, one bank when nothing is flagged
    assign span = owned_o ? (SPAN_W'(bank_cnt) << WORD_W) : SPAN_W'(BANK_WORDS);

    // Wrap into the span, then split into bank step and word
    assign offset = SPAN_W'(addr_i % span);
    assign bank_o = first_bank + BANK_IDX_W'(offset >> WORD_W);
    assign word_o = addr_i[WORD_W-1:0];

endmodule

/* src/glb_buffer.sv */
/*
 * Banked global buffer: banks, per-bank port priority,
 * write and read routing, and in-order read return per port
 */
`timescale 1ns/100ps

module glb_buffer #(
    parameter int BANK_WORDS = 16,
    parameter int NUM_WRPORT = 2,
    parameter int NUM_RDPORT = 2
) (
    input  logic                                 clk,
    input  logic                                 arst_n_i,
    input  glb_pkg::bank_mask_t [NUM_WRPORT-1:0] wr_mask_i,
    input  glb_pkg::bank_mask_t [NUM_RDPORT-1:0] rd_mask_i,
    input  glb_pkg::wr_req_t    [NUM_WRPORT-1:0] wr_req_i,
    input  logic                [NUM_WRPORT-1:0] wr_vld_i,
    output logic                [NUM_WRPORT-1:0] wr_rdy_o,
    input  glb_pkg::rd_req_t    [NUM_RDPORT-1:0] rd_req_i,
    input  logic                [NUM_RDPORT-1:0] ar_vld_i,
    output logic                [NUM_RDPORT-1:0] ar_rdy_o,
    output logic                [NUM_RDPORT-1:0] rd_vld_o,
    input  logic                [NUM_RDPORT-1:0] rd_rdy_i,
    output glb_pkg::word_t      [NUM_RDPORT-1:0] rd_data_o
);
    import glb_pkg::*;

    localparam int WORD_W = $clog2(BANK_WORDS);
    localparam int WP_W   = (NUM_WRPORT > 1) ? $clog2(NUM_WRPORT) : 1;
    localparam int RP_W   = (NUM_RDPORT > 1) ? $clog2(NUM_RDPORT) : 1;

    // Mapped bank and word per port
    bank_idx_t             wr_bank [NUM_WRPORT];
    logic [WORD_W-1:0]     wr_word [NUM_WRPORT];
    logic [NUM_WRPORT-1:0] wr_own;
    bank_idx_t             rd_bank [NUM_RDPORT];
    logic [WORD_W-1:0]     rd_word [NUM_RDPORT];
    logic [NUM_RDPORT-1:0] rd_own;
    logic [NUM_RDPORT-1:0] ar_hs;

    // Serving port per bank
    logic [WP_W-1:0]       wsel [NUM_BANK];
    logic [NUM_BANK-1:0]   wsel_vld;
    logic [RP_W-1:0]       rsel [NUM_BANK];
    logic [NUM_BANK-1:0]   rsel_vld;

    // Bank read side
    logic [NUM_BANK-1:0]   bk_ar_rdy;
    logic [NUM_BANK-1:0]   bk_rd_vld;
    word_t                 bk_rd_data [NUM_BANK];

    // ========================================
    // Fixed priority, lowest flagged port wins
    // ========================================
    always_comb begin
        for (int b = 0; b < NUM_BANK; b++) begin
            wsel[b]     = '0;
            wsel_vld[b] = 1'b0;
            rsel[b]     = '0;
            rsel_vld[b] = 1'b0;
            for (int p = NUM_WRPORT - 1; p >= 0; p--) begin
                if (wr_mask_i[p][b]) begin
                    wsel[b]     = WP_W'(p);
                    wsel_vld[b] = 1'b1;
                end
            end
            for (int p = NUM_RDPORT - 1; p >= 0; p--) begin
                if (rd_mask_i[p][b]) begin
                    rsel[b]     = RP_W'(p);
                    rsel_vld[b] = 1'b1;
                end
            end
        end
    end

    // ========================================
    // Write ports
    // ========================================
    for (genvar p = 0; p < NUM_WRPORT; p++) begin : g_wr_port
        glb_port_map #(
            .BANK_WORDS(BANK_WORDS)
        ) u_map (
            .mask_i (wr_mask_i[p]),
            .addr_i (wr_req_i[p].addr),
            .bank_o (wr_bank[p]),
            .word_o (wr_word[p]),
            .owned_o(wr_own[p])
        );

        // Ready only as the serving port of the mapped bank
        assign wr_rdy_o[p] = wr_own[p] && wsel_vld[wr_bank[p]]
                          && (wsel[wr_bank[p]] == WP_W'(p));
    end

    // ========================================
    // Read ports
    // ========================================
    for (genvar p = 0; p < NUM_RDPORT; p++) begin : g_rd_port
        logic      pend_q;
        bank_idx_t bank_q;
        logic      blocked;

        glb_port_map #(
            .BANK_WORDS(BANK_WORDS)
        ) u_map (
            .mask_i (rd_mask_i[p]),
            .addr_i (rd_req_i[p].addr),
            .bank_o (rd_bank[p]),
            .word_o (rd_word[p]),
            .owned_o(rd_own[p])
        );

        // Word from another bank still waiting, keeps order
        assign blocked = pend_q && (bank_q != rd_bank[p]) && !rd_rdy_i[p];

        assign ar_rdy_o[p] = rd_own[p] && rsel_vld[rd_bank[p]]
                          && (rsel[rd_bank[p]] == RP_W'(p))
                          && bk_ar_rdy[rd_bank[p]] && !blocked;
        assign ar_hs[p]    = ar_vld_i[p] && ar_rdy_o[p];

        // Return picked by the bank of the last accepted address
        assign rd_vld_o[p]  = pend_q && bk_rd_vld[bank_q];
        assign rd_data_o[p] = bk_rd_data[bank_q];

        always_ff @(posedge clk or negedge arst_n_i) begin
            if (!arst_n_i) begin
                pend_q <= 1'b0;
                bank_q <= '0;
            end else if (ar_hs[p]) begin
                pend_q <= 1'b1;
                bank_q <= rd_bank[p];
            end else if (rd_vld_o[p] && rd_rdy_i[p]) begin
                pend_q <= 1'b0;
            end
        end
    end

    // ========================================
    // Banks
    // ========================================
    for (genvar b = 0; b < NUM_BANK; b++) begin : g_bank
        logic bk_wr_vld;
        logic bk_ar_vld;
        logic bk_rd_rdy;

        // Route serving port only when it maps here
        assign bk_wr_vld = wsel_vld[b] && wr_vld_i[wsel[b]]
                        && (wr_bank[wsel[b]] == BANK_IDX_W'(b));
        assign bk_ar_vld = rsel_vld[b] && ar_hs[rsel[b]]
                        && (rd_bank[rsel[b]] == BANK_IDX_W'(b));
        // Held word always belongs to the serving read port
        assign bk_rd_rdy = rsel_vld[b] && rd_rdy_i[rsel[b]];

        glb_bank #(
            .BANK_WORDS(BANK_WORDS)
        ) u_bank (
            .clk      (clk),
            .arst_n_i (arst_n_i),
            .wr_vld_i (bk_wr_vld),
            .wr_addr_i(wr_word[wsel[b]]),
            .wr_data_i(wr_req_i[wsel[b]].data),
            .ar_vld_i (bk_ar_vld),
            .ar_addr_i(rd_word[rsel[b]]),
            .ar_rdy_o (bk_ar_rdy[b]),
            .rd_vld_o (bk_rd_vld[b]),
            .rd_rdy_i (bk_rd_rdy),
            .rd_data_o(bk_rd_data[b])
        );
    end

endmodule

/* src/glb_loader.sv */
/*
 * Producer lanes, input stream to addressed buffer writes
 */
`timescale 1ns/100ps

module glb_loader #(
    parameter int NUM_WRPORT = 2
) (
    input  logic                               clk,
    input  logic                               arst_n_i,
    input  logic               [NUM_WRPORT-1:0] start_i,
    input  glb_pkg::lane_cmd_t [NUM_WRPORT-1:0] cmd_i,
    input  glb_pkg::word_t     [NUM_WRPORT-1:0] in_data_i,
    input  logic               [NUM_WRPORT-1:0] in_vld_i,
    output logic               [NUM_WRPORT-1:0] in_rdy_o,
    output glb_pkg::wr_req_t   [NUM_WRPORT-1:0] wr_req_o,
    output logic               [NUM_WRPORT-1:0] wr_vld_o,
    input  logic               [NUM_WRPORT-1:0] wr_rdy_i,
    output logic               [NUM_WRPORT-1:0] done_o
);
    import glb_pkg::*;

    for (genvar l = 0; l < NUM_WRPORT; l++) begin : g_lane
        logic  busy_q;
        logic  done_q;
        addr_t addr_q;
        len_t  left_q;
        logic  wr_hs;

        // Input handshake is the buffer write
        assign wr_vld_o[l] = busy_q && in_vld_i[l];
        assign in_rdy_o[l] = busy_q && wr_rdy_i[l];
        assign wr_hs       = wr_vld_o[l] && wr_rdy_i[l];
        assign wr_req_o[l] = '{addr: addr_q, data: in_data_i[l]};
        assign done_o[l]   = done_q;

        always_ff @(posedge clk or negedge arst_n_i) begin
            if (!arst_n_i) begin
                busy_q <= 1'b0;
                done_q <= 1'b0;
                addr_q <= '0;
                left_q <= '0;
            end else begin
                done_q <= 1'b0;
                if (start_i[l] && !busy_q) begin
                    // Zero length finishes at once
                    busy_q <= (cmd_i[l].len != '0);
                    done_q <= (cmd_i[l].len == '0);
                    addr_q <= '0;
                    left_q <= cmd_i[l].len;
                end else if (wr_hs) begin
                    addr_q <= addr_q + 1'b1;
                    left_q <= left_q - 1'b1;
                    // Last word accepted
                    if (left_q == LEN_W'(1)) begin
                        busy_q <= 1'b0;
                        done_q <= 1'b1;
                    end
                end
            end
        end
    end

endmodule

/* src/glb_fetcher.sv */
/*
 * Consumer lanes, sequential read addresses and
 * the returned words forwarded to the output stream
 */
`timescale 1ns/100ps

module glb_fetcher #(
    parameter int NUM_RDPORT = 2
) (
    input  logic                                clk,
    input  logic                                arst_n_i,
    input  logic               [NUM_RDPORT-1:0] start_i,
    input  glb_pkg::lane_cmd_t [NUM_RDPORT-1:0] cmd_i,
    output glb_pkg::rd_req_t   [NUM_RDPORT-1:0] rd_req_o,
    output logic               [NUM_RDPORT-1:0] ar_vld_o,
    input  logic               [NUM_RDPORT-1:0] ar_rdy_i,
    input  logic               [NUM_RDPORT-1:0] rd_vld_i,
    output logic               [NUM_RDPORT-1:0] rd_rdy_o,
    input  glb_pkg::word_t     [NUM_RDPORT-1:0] rd_data_i,
    output glb_pkg::word_t     [NUM_RDPORT-1:0] out_data_o,
    output logic               [NUM_RDPORT-1:0] out_vld_o,
    input  logic               [NUM_RDPORT-1:0] out_rdy_i,
    output logic               [NUM_RDPORT-1:0] done_o
);
    import glb_pkg::*;

    for (genvar l = 0; l < NUM_RDPORT; l++) begin : g_lane
        addr_t iss_addr_q;
        len_t  iss_left_q;
        len_t  rcv_left_q;
        logic  done_q;
        logic  ar_hs;
        logic  out_hs;

        // Issue side
        assign ar_vld_o[l] = (iss_left_q != '0);
        assign rd_req_o[l] = '{addr: iss_addr_q};
        assign ar_hs       = ar_vld_o[l] && ar_rdy_i[l];

        // Return stream straight to the output
        assign out_data_o[l] = rd_data_i[l];
        assign out_vld_o[l]  = rd_vld_i[l];
        assign rd_rdy_o[l]   = out_rdy_i[l];
        assign out_hs        = rd_vld_i[l] && out_rdy_i[l];
        assign done_o[l]     = done_q;

        always_ff @(posedge clk or negedge arst_n_i) begin
            if (!arst_n_i) begin
                iss_addr_q <= '0;
                iss_left_q <= '0;
                rcv_left_q <= '0;
                done_q     <= 1'b0;
            end else begin
                done_q <= 1'b0;
                if (start_i[l] && rcv_left_q == '0) begin
                    iss_addr_q <= '0;
                    iss_left_q <= cmd_i[l].len;
                    rcv_left_q <= cmd_i[l].len;
                    done_q     <= (cmd_i[l].len == '0);
                end else begin
                    if (ar_hs) begin
                        iss_addr_q <= iss_addr_q + 1'b1;
                        iss_left_q <= iss_left_q - 1'b1;
                    end
                    // Count delivered words, done on the last one
                    if (out_hs && rcv_left_q != '0) begin
                        rcv_left_q <= rcv_left_q - 1'b1;
                        if (rcv_left_q == LEN_W'(1)) begin
                            done_q <= 1'b1;
                        end
                    end
                end
            end
        end
    end

endmodule

/* src/glb_top.sv */
/*
 * Top level, loader into global buffer into fetcher
 */
`timescale 1ns/100ps

module glb_top #(
    parameter int BANK_WORDS = 16,
    parameter int NUM_WRPORT = 2,
    parameter int NUM_RDPORT = 2
) (
    input  logic                                 clk,
    input  logic                                 arst_n_i,
    input  glb_pkg::bank_mask_t [NUM_WRPORT-1:0] wr_mask_i,
    input  glb_pkg::bank_mask_t [NUM_RDPORT-1:0] rd_mask_i,
    input  logic                [NUM_WRPORT-1:0] ld_start_i,
    input  glb_pkg::lane_cmd_t  [NUM_WRPORT-1:0] ld_cmd_i,
    input  glb_pkg::word_t      [NUM_WRPORT-1:0] in_data_i,
    input  logic                [NUM_WRPORT-1:0] in_vld_i,
    output logic                [NUM_WRPORT-1:0] in_rdy_o,
    output logic                [NUM_WRPORT-1:0] ld_done_o,
    input  logic                [NUM_RDPORT-1:0] ft_start_i,
    input  glb_pkg::lane_cmd_t  [NUM_RDPORT-1:0] ft_cmd_i,
    output glb_pkg::word_t      [NUM_RDPORT-1:0] out_data_o,
    output logic                [NUM_RDPORT-1:0] out_vld_o,
    input  logic                [NUM_RDPORT-1:0] out_rdy_i,
    output logic                [NUM_RDPORT-1:0] ft_done_o
);
    import glb_pkg::*;

    // Write channel
    wr_req_t [NUM_WRPORT-1:0] wr_req;
    logic    [NUM_WRPORT-1:0] wr_vld;
    logic    [NUM_WRPORT-1:0] wr_rdy;

    // Read address and return channels
    rd_req_t [NUM_RDPORT-1:0] rd_req;
    logic    [NUM_RDPORT-1:0] ar_vld;
    logic    [NUM_RDPORT-1:0] ar_rdy;
    logic    [NUM_RDPORT-1:0] rd_vld;
    logic    [NUM_RDPORT-1:0] rd_rdy;
    word_t   [NUM_RDPORT-1:0] rd_data;

    glb_loader #(
        .NUM_WRPORT(NUM_WRPORT)
    ) u_loader (
        .clk      (clk),
        .arst_n_i (arst_n_i),
        .start_i  (ld_start_i),
        .cmd_i    (ld_cmd_i),
        .in_data_i(in_data_i),
        .in_vld_i (in_vld_i),
        .in_rdy_o (in_rdy_o),
        .wr_req_o (wr_req),
        .wr_vld_o (wr_vld),
        .wr_rdy_i (wr_rdy),
        .done_o   (ld_done_o)
    );

    glb_buffer #(
        .BANK_WORDS(BANK_WORDS),
        .NUM_WRPORT(NUM_WRPORT),
        .NUM_RDPORT(NUM_RDPORT)
    ) u_buffer (
        .clk      (clk),
        .arst_n_i (arst_n_i),
        .wr_mask_i(wr_mask_i),
        .rd_mask_i(rd_mask_i),
        .wr_req_i (wr_req),
        .wr_vld_i (wr_vld),
        .wr_rdy_o (wr_rdy),
        .rd_req_i (rd_req),
        .ar_vld_i (ar_vld),
        .ar_rdy_o (ar_rdy),
        .rd_vld_o (rd_vld),
        .rd_rdy_i (rd_rdy),
        .rd_data_o(rd_data)
    );

    glb_fetcher #(
        .NUM_RDPORT(NUM_RDPORT)
    ) u_fetcher (
        .clk       (clk),
        .arst_n_i  (arst_n_i),
        .start_i   (ft_start_i),
        .cmd_i     (ft_cmd_i),
        .rd_req_o  (rd_req),
        .ar_vld_o  (ar_vld),
        .ar_rdy_i  (ar_rdy),
        .rd_vld_i  (rd_vld),
        .rd_rdy_o  (rd_rdy),
        .rd_data_i (rd_data),
        .out_data_o(out_data_o),
        .out_vld_o (out_vld_o),
        .out_rdy_i (out_rdy_i),
        .done_o    (ft_done_o)
    );

endmodule

/* test/glb_top_props.sv */
/*
 * Concurrent checks on the buffer read handshakes, bound into glb_buffer
 */
`timescale 1ns/100ps

module glb_top_tb_props #(
    parameter int NUM_RDPORT = 2
) (
    input logic                                 clk,
    input logic                                 arst_n_i,
    input glb_pkg::bank_mask_t [NUM_RDPORT-1:0] rd_mask_i,
    input logic                [NUM_RDPORT-1:0] ar_vld_i,
    input logic                [NUM_RDPORT-1:0] ar_rdy_o,
    input logic                [NUM_RDPORT-1:0] rd_vld_o,
    input logic                [NUM_RDPORT-1:0] rd_rdy_i,
    input glb_pkg::word_t      [NUM_RDPORT-1:0] rd_data_o
);

    // Nothing valid on the first edge out of reset
    a_rst_idle: assert property (@(posedge clk) $rose(arst_n_i) |-> (rd_vld_o == '0))
        else $error("read valid set in the first cycle after reset");

    for (genvar p = 0; p < NUM_RDPORT; p++) begin : g_port
        // Stalled return keeps valid and data
        a_hold: assert property (@(posedge clk) disable iff (!arst_n_i)
            (rd_vld_o[p] && !rd_rdy_i[p]) |=> (rd_vld_o[p] && $stable(rd_data_o[p])))
            else $error("read port %0d return changed while stalled", p);

        // Port without banks never takes an address
        a_no_owner: assert property (@(posedge clk) disable iff (!arst_n_i)
            !(ar_vld_i[p] && ar_rdy_o[p] && (rd_mask_i[p] == '0)))
            else $error("read port %0d took an address with an empty mask", p);
    end

endmodule

bind glb_buffer glb_top_tb_props #(
    .NUM_RDPORT(NUM_RDPORT)
) u_props (
    .clk      (clk),
    .arst_n_i (arst_n_i),
    .rd_mask_i(rd_mask_i),
    .ar_vld_i (ar_vld_i),
    .ar_rdy_o (ar_rdy_o),
    .rd_vld_o (rd_vld_o),
    .rd_rdy_i (rd_rdy_i),
    .rd_data_o(rd_data_o)
);

/* test/glb_top_tb.sv */
/*
 * Testbench for the global buffer top level: scenario table,
 * reference bank model, compare tasks and a cycle limit
 */
`timescale 1ns/100ps

module glb_top_tb;
    import glb_pkg::*;

    localparam int BANK_WORDS   = 16;
    localparam int NWR          = 2;
    localparam int NRD          = 2;
    localparam int NUM_ROWS     = 8;
    // Slowdown under output stalls, slack for reset and config
    localparam int STALL_FACTOR = 3;
    localparam int MARGIN       = 200;

    // One scenario, lane 1 in the upper field, stall in percent
    typedef struct packed {
        bank_mask_t [NWR-1:0] wr_mask;
        bank_mask_t [NRD-1:0] rd_mask;
        len_t       [NWR-1:0] wlen;
        len_t       [NRD-1:0] rlen;
        logic       [7:0]     stall;
    } row_t;

    row_t rows [NUM_ROWS] = '{
        // Single bank, straight copy
        '{wr_mask: {4'b0000, 4'b0001}, rd_mask: {4'b0000, 4'b0001},
          wlen: {8'd0, 8'd16}, rlen: {8'd0, 8'd16}, stall: 8'd0},
        // Two banks, read crosses the boundary
        '{wr_mask: {4'b0000, 4'b0110}, rd_mask: {4'b0000, 4'b0110},
          wlen: {8'd0, 8'd32}, rlen: {8'd0, 8'd32}, stall: 8'd0},
        // Longer than the span, addresses wrap
        '{wr_mask: {4'b0000, 4'b0001}, rd_mask: {4'b0000, 4'b0001},
          wlen: {8'd0, 8'd40}, rlen: {8'd0, 8'd40}, stall: 8'd0},
        // All four ports at once on disjoint banks
        '{wr_mask: {4'b1100, 4'b0011}, rd_mask: {4'b1100, 4'b0011},
          wlen: {8'd32, 8'd32}, rlen: {8'd32, 8'd32}, stall: 8'd0},
        // Read port 1 reads what write port 0 wrote, bank 1 shared by both writers
        '{wr_mask: {4'b0110, 4'b0011}, rd_mask: {4'b0011, 4'b0000},
          wlen: {8'd0, 8'd32}, rlen: {8'd32, 8'd0}, stall: 8'd0},
        // Random output stalls
        '{wr_mask: {4'b0000, 4'b1111}, rd_mask: {4'b1100, 4'b0011},
          wlen: {8'd0, 8'd64}, rlen: {8'd32, 8'd32}, stall: 8'd40},
        '{wr_mask: {4'b1100, 4'b0011}, rd_mask: {4'b0000, 4'b1111},
          wlen: {8'd32, 8'd32}, rlen: {8'd0, 8'd64}, stall: 8'd60},
        // Read lane 1 started with no banks, never served, so it stays last
        '{wr_mask: {4'b0000, 4'b0011}, rd_mask: {4'b0000, 4'b0011},
          wlen: {8'd0, 8'd16}, rlen: {8'd8, 8'd16}, stall: 8'd0}
    };

    logic                 clk;
    logic                 arst_n_i;
    bank_mask_t [NWR-1:0] wr_mask_i;
    bank_mask_t [NRD-1:0] rd_mask_i;
    logic       [NWR-1:0] ld_start_i;
    lane_cmd_t  [NWR-1:0] ld_cmd_i;
    word_t      [NWR-1:0] in_data_i;
    logic       [NWR-1:0] in_vld_i;
    logic       [NWR-1:0] in_rdy_o;
    logic       [NWR-1:0] ld_done_o;
    logic       [NRD-1:0] ft_start_i;
    lane_cmd_t  [NRD-1:0] ft_cmd_i;
    word_t      [NRD-1:0] out_data_o;
    logic       [NRD-1:0] out_vld_o;
    logic       [NRD-1:0] out_rdy_i;
    logic       [NRD-1:0] ft_done_o;

    // Reference banks and expected read streams
    word_t ref_mem [NUM_BANK][BANK_WORDS];
    word_t exp_q [NRD][$];
    // Loader address left over from the previous run
    addr_t last_addr [NWR] = '{default: '0};
    int    seed       = 62165;
    int    word_errs  = 0;
    int    count_errs = 0;
    int    flag_errs  = 0;
    int    cycle_cnt  = 0;

    glb_top #(
        .BANK_WORDS(BANK_WORDS),
        .NUM_WRPORT(NWR),
        .NUM_RDPORT(NRD)
    ) glb_top_inst (.*);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // ========================================
    // Reference rules
    // ========================================
    // Lowest flagged bank plus the step inside the span
    function automatic int map_bank(input bank_mask_t mask, input int addr);
        int first;
        int cnt;
        int span;
        first = 0;
        cnt   = 0;
        for (int b = NUM_BANK - 1; b >= 0; b--) begin
            if (mask[b]) begin
                first = b;
                cnt++;
            end
        end
        span = (cnt == 0) ? BANK_WORDS : cnt * BANK_WORDS;
        return (first + (addr % span) / BANK_WORDS) % NUM_BANK;
    endfunction

    // Lowest write port flagging the bank, -1 when none
    function automatic int serving_wr_port(input bank_mask_t [NWR-1:0] masks, input int bank);
        int port;
        port = -1;
        for (int p = NWR - 1; p >= 0; p--) begin
            if (masks[p][bank]) begin
                port = p;
            end
        end
        return port;
    endfunction

    // ========================================
    // Compare tasks
    // ========================================
    task automatic check_word(input word_t got, input word_t exp, input int lane, input int idx);
        if (got !== exp) begin
            word_errs++;
            $display("FAILED at %0t: lane %0d word %0d is %08h, expected %08h",
                     $time, lane, idx, got, exp);
        end
    endtask

    task automatic check_count(input len_t got, input len_t exp, input string what,
                               input int lane);
        if (got !== exp) begin
            count_errs++;
            $display("FAILED at %0t: %s lane %0d counted %0d words at done, expected %0d",
                     $time, what, lane, got, exp);
        end
    endtask

    task automatic check_flag(input logic got, input logic exp, input int port);
        if (got !== exp) begin
            flag_errs++;
            $display("FAILED at %0t: write port %0d ready is %0b, expected %0b",
                     $time, port, got, exp);
        end
    endtask

    task automatic print_counts();
        $display("Errors: data %0d, count %0d, ready %0d", word_errs, count_errs, flag_errs);
    endtask

    // ========================================
    // Scenario phases
    // ========================================
    task automatic configure(input row_t row);
        logic exp_rdy;
        int   bank;
        @(negedge clk);
        wr_mask_i = row.wr_mask;
        rd_mask_i = row.rd_mask;
        #1;
        // Write ready only for the serving port of the mapped bank
        for (int p = 0; p < NWR; p++) begin
            bank    = map_bank(row.wr_mask[p], int'(last_addr[p]));
            exp_rdy = (row.wr_mask[p] != '0) && (serving_wr_port(row.wr_mask, bank) == p);
            check_flag(glb_top_inst.u_buffer.wr_rdy_o[p], exp_rdy, p);
        end
    endtask

    task automatic load_phase(input row_t row);
        int             sent [NWR];
        word_t          cur_data [NWR];
        logic [NWR-1:0] active;
        logic [NWR-1:0] done_seen;
        for (int l = 0; l < NWR; l++) begin
            sent[l]         = 0;
            active[l]       = (row.wlen[l] != '0);
            cur_data[l]     = $random(seed);
            ld_cmd_i[l].len = row.wlen[l];
        end
        @(negedge clk);
        ld_start_i = active;
        @(negedge clk);
        ld_start_i = '0;
        done_seen  = ~active;
        while (done_seen != '1) begin
            for (int l = 0; l < NWR; l++) begin
                in_vld_i[l]  = active[l] && (sent[l] < int'(row.wlen[l]));
                in_data_i[l] = cur_data[l];
            end
            #1;
            for (int l = 0; l < NWR; l++) begin
                if (ld_done_o[l]) begin
                    done_seen[l] = 1'b1;
                    check_count(len_t'(sent[l]), row.wlen[l], "loader", l);
                end
                // Accepted on the coming edge, goes into the model now
                if (in_vld_i[l] && in_rdy_o[l]) begin
                    ref_mem[map_bank(row.wr_mask[l], sent[l])][sent[l] % BANK_WORDS]
                        = cur_data[l];
                    sent[l]++;
                    cur_data[l] = $random(seed);
                end
            end
            @(negedge clk);
        end
        in_vld_i = '0;
        for (int l = 0; l < NWR; l++) begin
            if (active[l]) begin
                last_addr[l] = addr_t'(row.wlen[l]);
            end
        end
    endtask

    task automatic fetch_phase(input row_t row);
        int             rcvd [NRD];
        logic [NRD-1:0] active;
        logic [NRD-1:0] owned;
        logic [NRD-1:0] done_seen;
        word_t          exp_w;
        for (int l = 0; l < NRD; l++) begin
            rcvd[l]   = 0;
            active[l] = (row.rlen[l] != '0);
            owned[l]  = (row.rd_mask[l] != '0);
            exp_q[l].delete();
            // A lane without banks returns nothing
            if (owned[l]) begin
                for (int a = 0; a < int'(row.rlen[l]); a++) begin
                    exp_q[l].push_back(ref_mem[map_bank(row.rd_mask[l], a)][a % BANK_WORDS]);
                end
            end
            ft_cmd_i[l].len = row.rlen[l];
        end
        @(negedge clk);
        ft_start_i = active;
        @(negedge clk);
        ft_start_i = '0;
        done_seen  = ~(active & owned);
        while (done_seen != '1) begin
            for (int l = 0; l < NRD; l++) begin
                out_rdy_i[l] = ($unsigned($random(seed)) % 100) >= row.stall;
            end
            #1;
            for (int l = 0; l < NRD; l++) begin
                // Done one cycle after the last output word
                if (ft_done_o[l]) begin
                    done_seen[l] = 1'b1;
                    check_count(len_t'(rcvd[l]), row.rlen[l], "fetcher", l);
                end
                if (out_vld_o[l] && out_rdy_i[l]) begin
                    if (exp_q[l].size() == 0) begin
                        count_errs++;
                        $display("Lane %0d sent a word beyond its expected stream at %0t",
                                 l, $time);
                    end else begin
                        exp_w = exp_q[l].pop_front();
                        check_word(out_data_o[l], exp_w, l, rcvd[l]);
                    end
                    rcvd[l]++;
                end
            end
            @(negedge clk);
        end
        out_rdy_i = '0;
    endtask

    // ========================================
    // Main sequence and cycle limit
    // ========================================
    initial begin
        arst_n_i   = 1'b0;
        wr_mask_i  = '0;
        rd_mask_i  = '0;
        ld_start_i = '0;
        ld_cmd_i   = '0;
        in_data_i  = '0;
        in_vld_i   = '0;
        ft_start_i = '0;
        ft_cmd_i   = '0;
        out_rdy_i  = '0;
        repeat (2) @(posedge clk);
        @(negedge clk);
        arst_n_i = 1'b1;
        for (int r = 0; r < NUM_ROWS; r++) begin
            configure(rows[r]);
            load_phase(rows[r]);
            fetch_phase(rows[r]);
        end
        repeat (2) @(negedge clk);
        print_counts();
        if (word_errs + count_errs + flag_errs == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

    initial begin : watchdog
        int limit;
        int total;
        total = 0;
        for (int r = 0; r < NUM_ROWS; r++) begin
            for (int l = 0; l < NWR; l++) begin
                total += int'(rows[r].wlen[l]);
            end
            for (int l = 0; l < NRD; l++) begin
                total += int'(rows[r].rlen[l]);
            end
        end
        limit = 4 * total * STALL_FACTOR + MARGIN;
        while (cycle_cnt < limit) begin
            @(posedge clk);
            cycle_cnt++;
        end
        $display("Timeout: run still busy after %0d cycles", cycle_cnt);
        print_counts();
        $display("Result: FAILED");
        $finish;
    end

endmodule

/* glb_top.f */
src/glb_pkg.sv
src/glb_bank.sv
src/glb_port_map.sv
src/glb_buffer.sv
src/glb_loader.sv
src/glb_fetcher.sv
src/glb_top.sv
test/glb_top_props.sv
test/glb_top_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build the global buffer testbench with Verilator, run it, look for the pass line
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --timescale 1ns/100ps \
    --top-module glb_top_tb -f glb_top.f -o glb_top_sim \
    && ./obj_dir/glb_top_sim | tee /dev/stderr | grep -qx "Result: PASSED" \
    && echo "Simulation passed" \
    || { echo "Simulation failed"; exit 1; }
